// File: project.f
+incdir+source
source/bridge_pkg.sv
source/axi_request_decode.sv
source/apb_transfer_engine.sv
source/axi_response_gen.sv
source/axi_apb_bridge.sv
sim/apb_clock_gen.sv
sim/tb_axi_apb_bridge.sv

// File: sim/bridge_tests.txt
# columns: test name, operation R or W, address hex, write data hex, wait states decimal,
# expected read data hex, expected response (0 okay, 2 slverr, 3 decerr); 255 waits never ready
wr_slave0         W 00000010 11110000 0   00000000 0
rd_slave0         R 00000010 00000000 0   11110000 0
wr_slave1         W 00001020 22220001 0   00000000 0
rd_slave1         R 00001020 00000000 0   22220001 0
wr_slave2         W 00002030 33330002 0   00000000 0
rd_slave2         R 00002030 00000000 0   33330002 0
wr_slave3         W 00003ffc 44440003 0   00000000 0
rd_slave3         R 00003ffc 00000000 0   44440003 0
rd_fill_slave3    R 00003040 00000000 0   c0de3040 0
rd_fill_slave1    R 00001abc 00000000 0   c0de1abc 0
wr_wait1          W 00000100 5a5a0101 1   00000000 0
rd_wait2          R 00000100 00000000 2   5a5a0101 0
wr_wait3          W 00001104 a5a50104 3   00000000 0
rd_wait4          R 00001104 00000000 4   a5a50104 0
wr_wait5          W 00002108 0badf00d 5   00000000 0
rd_wait5          R 00002108 00000000 5   0badf00d 0
wr_slverr         W 000010ff deadbeef 0   00000000 2
rd_slverr         R 000010ff 00000000 2   00000000 2
rd_slverr_slave3  R 000033ff 00000000 0   00000000 2
rd_timeout        R 00002000 00000000 255 00000000 2
rd_after_timeout  R 00002030 00000000 0   33330002 0
wr_timeout        W 00000020 ffffffff 255 00000000 2
rd_after_wr_tmo   R 00000020 00000000 0   c0de0020 0
rd_decerr         R 00004000 00000000 0   00000000 3
wr_decerr         W 00004ff0 12345678 0   00000000 3
rd_decerr_high    R ffff0000 00000000 0   00000000 3
rd_after_decerr   R 00003ffc 00000000 1   44440003 0

// File: sim/tb_axi_apb_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the AXI-Lite to APB3 bridge.
// Reads tests from a data file, drives the AXI side, models four APB
// slaves with wait states and errors, and checks every response.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_axi_apb_bridge
	import bridge_pkg::*;
;

	localparam int CH_AR = 0;
	localparam int CH_AW = 1;
	localparam int CH_W  = 2;
	localparam int WORDS = 1 << (`BRIDGE_REGION_LOG2 - 2);

	logic                                         s_axi_clk;
	logic                                         s_axi_aresetn;
	logic [`BRIDGE_ADDR_W-1:0]                    s_axi_awaddr;
	logic                                         s_axi_awvalid;
	logic                                         s_axi_awready;
	logic [`BRIDGE_DATA_W-1:0]                    s_axi_wdata;
	logic                                         s_axi_wvalid;
	logic                                         s_axi_wready;
	logic [1:0]                                   s_axi_bresp;
	logic                                         s_axi_bvalid;
	logic                                         s_axi_bready;
	logic [`BRIDGE_ADDR_W-1:0]                    s_axi_araddr;
	logic                                         s_axi_arvalid;
	logic                                         s_axi_arready;
	logic [`BRIDGE_DATA_W-1:0]                    s_axi_rdata;
	logic [1:0]                                   s_axi_rresp;
	logic                                         s_axi_rvalid;
	logic                                         s_axi_rready;
	logic [`BRIDGE_ADDR_W-1:0]                    m_apb_paddr;
	logic [`BRIDGE_NUM_SLAVES-1:0]                m_apb_psel;
	logic                                         m_apb_penable;
	logic                                         m_apb_pwrite;
	logic [`BRIDGE_DATA_W-1:0]                    m_apb_pwdata;
	logic [`BRIDGE_NUM_SLAVES-1:0]                m_apb_pready;
	logic [`BRIDGE_NUM_SLAVES*`BRIDGE_DATA_W-1:0] m_apb_prdata;
	logic [`BRIDGE_NUM_SLAVES-1:0]                m_apb_pslverr;

	// test table, one entry per data file line.
	string                     t_name[$];
	string                     t_op[$];
	logic [`BRIDGE_ADDR_W-1:0] t_addr[$];
	logic [`BRIDGE_DATA_W-1:0] t_wdata[$];
	int                        t_wait[$];
	logic [`BRIDGE_DATA_W-1:0] t_exp_data[$];
	logic [1:0]                t_exp_resp[$];

	logic [`BRIDGE_DATA_W-1:0] slave_mem [0:`BRIDGE_NUM_SLAVES-1][0:WORDS-1];
	integer                    seed = 67381;
	int                        n_tests = 0;
	int                        pass_count = 0;
	int                        fail_count = 0;
	int                        write_index = 0;
	int                        cur_wait = 0;
	int                        wait_cnt = 0;
	logic                      psel_seen = 1'b0;
	logic                      cur_write = 1'b0;
	logic                      pwrite_bad = 1'b0;
	logic                      test_failed;

	apb_clock_gen #(.PERIOD_NS(4.0)) i_apb_clock_gen (.clk(s_axi_clk));

	axi_apb_bridge i_axi_apb_bridge (.*);

	// APB slave model, answers on the falling edge after the wait states.
	always @(negedge s_axi_clk) begin
		m_apb_pready  = '0;
		m_apb_pslverr = '0;
		m_apb_prdata  = '0;
		if (m_apb_penable && (m_apb_psel != '0)) begin
			if ((cur_wait != 255) && (wait_cnt >= cur_wait)) begin
				for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
					if (m_apb_psel[i]) begin
						m_apb_pready[i]  = 1'b1;
						m_apb_pslverr[i] = (m_apb_paddr[7:0] == 8'hff);
						m_apb_prdata[i*`BRIDGE_DATA_W +: `BRIDGE_DATA_W] =
							slave_mem[i][m_apb_paddr[`BRIDGE_REGION_LOG2-1:2]];
						if (m_apb_pwrite && !m_apb_pslverr[i]) begin
							slave_mem[i][m_apb_paddr[`BRIDGE_REGION_LOG2-1:2]] = m_apb_pwdata;
						end
					end
				end
			end
			wait_cnt = wait_cnt + 1;
		end else begin
			wait_cnt = 0;
		end
	end

	// select and write flag as seen by the slaves.
	always @(posedge s_axi_clk) begin
		if (m_apb_psel != '0) begin
			psel_seen = 1'b1;
			if (m_apb_pwrite !== cur_write) begin
				pwrite_bad = 1'b1;
			end
		end
	end

	// watchdog, sized from the number of tests.
	initial begin
		wait (n_tests > 0);
		repeat (n_tests * (`BRIDGE_TIMEOUT_CYCLES + 40)) @(posedge s_axi_clk);
		$display("watchdog expired: the bridge stopped answering before all tests ran");
		$display("Test failures found");
		$finish;
	end

	function automatic logic channel_ready(input int which);
		case (which)
			CH_AR:   channel_ready = s_axi_arready;
			CH_AW:   channel_ready = s_axi_awready;
			default: channel_ready = s_axi_wready;
		endcase
	endfunction

	task automatic compare_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %h, actual %h", name, what, expected, actual);
			test_failed = 1'b1;
		end
	endtask

	task automatic load_tests();
		int                        fd;
		int                        fields;
		logic [8*200-1:0]          line;
		string                     name;
		string                     op;
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_DATA_W-1:0] wdata;
		int                        waits;
		logic [`BRIDGE_DATA_W-1:0] exp_data;
		logic [1:0]                exp_resp;
		fd = $fopen("sim/bridge_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test file sim/bridge_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					// comment and blank lines do not give all seven fields.
					fields = $sscanf(line, "%s %s %h %h %d %h %h", name, op, addr, wdata,
						waits, exp_data, exp_resp);
					if (fields == 7) begin
						t_name.push_back(name);
						t_op.push_back(op);
						t_addr.push_back(addr);
						t_wdata.push_back(wdata);
						t_wait.push_back(waits);
						t_exp_data.push_back(exp_data);
						t_exp_resp.push_back(exp_resp);
					end
				end
			end
			$fclose(fd);
		end
		n_tests = t_name.size();
	endtask

	task automatic push_channel(input int which, input logic [31:0] value);
		@(negedge s_axi_clk);
		case (which)
			CH_AR: begin
				s_axi_araddr  = value;
				s_axi_arvalid = 1'b1;
			end
			CH_AW: begin
				s_axi_awaddr  = value;
				s_axi_awvalid = 1'b1;
			end
			default: begin
				s_axi_wdata  = value;
				s_axi_wvalid = 1'b1;
			end
		endcase
		#1;
		while (!channel_ready(which)) begin
			@(negedge s_axi_clk);
			#1;
		end
		// handshake happens on the rising edge in between.
		@(negedge s_axi_clk);
		s_axi_arvalid = 1'b0;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
	endtask

	task automatic collect_response(input logic is_read, input string name,
		input logic [31:0] exp_data, input logic [1:0] exp_resp);
		logic [31:0] held_data;
		logic [1:0]  held_resp;
		int          hold;
		while (!(is_read ? s_axi_rvalid : s_axi_bvalid)) begin
			@(negedge s_axi_clk);
		end
		held_data = is_read ? s_axi_rdata : 32'd0;
		held_resp = is_read ? s_axi_rresp : s_axi_bresp;
		if (is_read) begin
			compare_value(name, "rdata", exp_data, held_data);
		end
		compare_value(name, "resp", exp_resp, held_resp);
		hold = {$random(seed)} % 5;
		repeat (hold) begin
			@(negedge s_axi_clk);
			compare_value(name, "valid held", 1, is_read ? s_axi_rvalid : s_axi_bvalid);
			if (is_read) begin
				compare_value(name, "data held", held_data, s_axi_rdata);
			end
			compare_value(name, "resp held", held_resp, is_read ? s_axi_rresp : s_axi_bresp);
		end
		s_axi_rready = is_read;
		s_axi_bready = !is_read;
		@(negedge s_axi_clk);
		s_axi_rready = 1'b0;
		s_axi_bready = 1'b0;
		compare_value(name, "valid after handshake", 0, is_read ? s_axi_rvalid : s_axi_bvalid);
	endtask

	task automatic run_test(input int t);
		int gap;
		test_failed = 1'b0;
		@(negedge s_axi_clk);
		cur_wait   = t_wait[t];
		psel_seen  = 1'b0;
		cur_write  = (t_op[t] != "R");
		pwrite_bad = 1'b0;
		if (t_op[t] == "R") begin
			push_channel(CH_AR, t_addr[t]);
		end else begin
			gap = {$random(seed)} % 4;
			// alternate which half goes first.
			if ((write_index % 2) == 0) begin
				push_channel(CH_AW, t_addr[t]);
				repeat (gap) @(negedge s_axi_clk);
				push_channel(CH_W, t_wdata[t]);
			end else begin
				push_channel(CH_W, t_wdata[t]);
				repeat (gap) @(negedge s_axi_clk);
				push_channel(CH_AW, t_addr[t]);
			end
			write_index++;
		end
		collect_response(t_op[t] == "R", t_name[t], t_exp_data[t], t_exp_resp[t]);
		if ((t_exp_resp[t] == resp_decerr) && psel_seen) begin
			$display("an APB select line went high during decode error test %s", t_name[t]);
			test_failed = 1'b1;
		end
		if (pwrite_bad) begin
			$display("the APB write flag did not match the operation in test %s", t_name[t]);
			test_failed = 1'b1;
		end
		if (test_failed) begin
			fail_count++;
			$display("FAIL %s", t_name[t]);
		end else begin
			pass_count++;
			$display("PASS %s", t_name[t]);
		end
	endtask

	initial begin
		s_axi_aresetn = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		m_apb_pready  = '0;
		m_apb_prdata  = '0;
		m_apb_pslverr = '0;
		// each word starts as its own byte address with a marker on top.
		for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
			for (int w = 0; w < WORDS; w++) begin
				slave_mem[s][w] = 32'hc0de0000 | (s << `BRIDGE_REGION_LOG2) | (w << 2);
			end
		end
		load_tests();
		if (n_tests == 0) begin
			$display("no test could be read from sim/bridge_tests.txt");
			fail_count = 1;
		end else begin
			repeat (4) @(posedge s_axi_clk);
			@(negedge s_axi_clk);
			s_axi_aresetn = 1'b1;
			for (int t = 0; t < n_tests; t++) begin
				run_test(t);
			end
		end
		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: sim/apb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock generator.
// Free running clock, low at time zero, 4 ns period by default.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk = ~clk;
		end
	end

endmodule

// File: source/axi_apb_bridge.sv
////////////////////////////////////////////////////////////////////////////
// AXI-Lite slave to APB3 master bridge, top level.
// Request decode, APB transfer engine and response generation for four
// APB slaves, one transaction at a time.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bridge_macros.svh"

module axi_apb_bridge
	import bridge_pkg::*;
(
	input  logic                                         s_axi_clk,
	input  logic                                         s_axi_aresetn,

	input  logic [`BRIDGE_ADDR_W-1:0]                    s_axi_awaddr,
	input  logic                                         s_axi_awvalid,
	output logic                                         s_axi_awready,
	input  logic [`BRIDGE_DATA_W-1:0]                    s_axi_wdata,
	input  logic                                         s_axi_wvalid,
	output logic                                         s_axi_wready,
	output logic [1:0]                                   s_axi_bresp,
	output logic                                         s_axi_bvalid,
	input  logic                                         s_axi_bready,
	input  logic [`BRIDGE_ADDR_W-1:0]                    s_axi_araddr,
	input  logic                                         s_axi_arvalid,
	output logic                                         s_axi_arready,
	output logic [`BRIDGE_DATA_W-1:0]                    s_axi_rdata,
	output logic [1:0]                                   s_axi_rresp,
	output logic                                         s_axi_rvalid,
	input  logic                                         s_axi_rready,

	output logic [`BRIDGE_ADDR_W-1:0]                    m_apb_paddr,
	output logic [`BRIDGE_NUM_SLAVES-1:0]                m_apb_psel,
	output logic                                         m_apb_penable,
	output logic                                         m_apb_pwrite,
	output logic [`BRIDGE_DATA_W-1:0]                    m_apb_pwdata,
	input  logic [`BRIDGE_NUM_SLAVES-1:0]                m_apb_pready,
	input  logic [`BRIDGE_NUM_SLAVES*`BRIDGE_DATA_W-1:0] m_apb_prdata,
	input  logic [`BRIDGE_NUM_SLAVES-1:0]                m_apb_pslverr
);

	logic                           xfer_start;
	logic                           decerr_start;
	xfer_kind_e                     xfer_kind;
	logic [`BRIDGE_ADDR_W-1:0]      xfer_addr;
	logic [`BRIDGE_DATA_W-1:0]      xfer_wdata;
	logic [`BRIDGE_SLAVE_SEL_W-1:0] xfer_slave;
	logic                           apb_done;
	logic [`BRIDGE_DATA_W-1:0]      apb_rdata;
	logic                           apb_err;
	logic                           resp_done;

	axi_request_decode i_axi_request_decode (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.resp_done     (resp_done),
		.xfer_start    (xfer_start),
		.decerr_start  (decerr_start),
		.xfer_kind     (xfer_kind),
		.xfer_addr     (xfer_addr),
		.xfer_wdata    (xfer_wdata),
		.xfer_slave    (xfer_slave)
	);

	apb_transfer_engine i_apb_transfer_engine (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.xfer_start    (xfer_start),
		.xfer_kind     (xfer_kind),
		.xfer_addr     (xfer_addr),
		.xfer_wdata    (xfer_wdata),
		.xfer_slave    (xfer_slave),
		.m_apb_paddr   (m_apb_paddr),
		.m_apb_psel    (m_apb_psel),
		.m_apb_penable (m_apb_penable),
		.m_apb_pwrite  (m_apb_pwrite),
		.m_apb_pwdata  (m_apb_pwdata),
		.m_apb_pready  (m_apb_pready),
		.m_apb_prdata  (m_apb_prdata),
		.m_apb_pslverr (m_apb_pslverr),
		.apb_done      (apb_done),
		.apb_rdata     (apb_rdata),
		.apb_err       (apb_err)
	);

	axi_response_gen i_axi_response_gen (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.apb_done      (apb_done),
		.apb_rdata     (apb_rdata),
		.apb_err       (apb_err),
		.decerr_start  (decerr_start),
		.xfer_kind     (xfer_kind),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rready  (s_axi_rready),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bready  (s_axi_bready),
		.resp_done     (resp_done)
	);

endmodule

// File: source/axi_response_gen.sv
////////////////////////////////////////////////////////////////////////////
// AXI-Lite response generation.
// Turns the end of an APB transfer or a decode error into a read or
// write response and holds it until the master accepts it.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bridge_macros.svh"

module axi_response_gen
	import bridge_pkg::*;
(
	input  logic                      s_axi_clk,
	input  logic                      s_axi_aresetn,

	input  logic                      apb_done,
	input  logic [`BRIDGE_DATA_W-1:0] apb_rdata,
	input  logic                      apb_err,
	input  logic                      decerr_start,
	input  xfer_kind_e                xfer_kind,

	output logic                      s_axi_rvalid,
	output logic [`BRIDGE_DATA_W-1:0] s_axi_rdata,
	output logic [1:0]                s_axi_rresp,
	input  logic                      s_axi_rready,
	output logic                      s_axi_bvalid,
	output logic [1:0]                s_axi_bresp,
	input  logic                      s_axi_bready,

	output logic                      resp_done
);

	axi_resp_e end_code;
	logic      finish;

	assign finish = apb_done || decerr_start;

	always_comb begin
		if (decerr_start) begin
			end_code = resp_decerr;
		end else if (apb_err) begin
			end_code = resp_slverr;
		end else begin
			end_code = resp_okay;
		end
	end

	assign resp_done = (s_axi_rvalid && s_axi_rready) || (s_axi_bvalid && s_axi_bready);

	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			s_axi_rvalid <= 1'b0;
			s_axi_bvalid <= 1'b0;
		end else begin
			if (finish && (xfer_kind == xfer_read)) begin
				s_axi_rvalid <= 1'b1;
			end else if (s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
			end
			if (finish && (xfer_kind == xfer_write)) begin
				s_axi_bvalid <= 1'b1;
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	// response payload, loaded once per transfer.
	always_ff @(posedge s_axi_clk) begin
		if (finish) begin
			if (xfer_kind == xfer_read) begin
				s_axi_rresp <= end_code;
				// no data goes back with an error.
				if (end_code == resp_okay) begin
					s_axi_rdata <= apb_rdata;
				end else begin
					s_axi_rdata <= '0;
				end
			end else begin
				s_axi_bresp <= end_code;
			end
		end
	end

endmodule

// File: source/apb_transfer_engine.sv
////////////////////////////////////////////////////////////////////////////
// APB3 transfer engine.
// Runs one setup and access sequence per request, selects the addressed
// slave's ready, error and read data, and ends a stalled access after a
// fixed number of cycles.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bridge_macros.svh"

module apb_transfer_engine
	import bridge_pkg::*;
(
	input  logic                                          s_axi_clk,
	input  logic                                          s_axi_aresetn,

	input  logic                                          xfer_start,
	input  xfer_kind_e                                    xfer_kind,
	input  logic [`BRIDGE_ADDR_W-1:0]                     xfer_addr,
	input  logic [`BRIDGE_DATA_W-1:0]                     xfer_wdata,
	input  logic [`BRIDGE_SLAVE_SEL_W-1:0]                xfer_slave,

	output logic [`BRIDGE_ADDR_W-1:0]                     m_apb_paddr,
	output logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_psel,
	output logic                                          m_apb_penable,
	output logic                                          m_apb_pwrite,
	output logic [`BRIDGE_DATA_W-1:0]                     m_apb_pwdata,
	input  logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_pready,
	input  logic [`BRIDGE_NUM_SLAVES*`BRIDGE_DATA_W-1:0]  m_apb_prdata,
	input  logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_pslverr,

	output logic                                          apb_done,
	output logic [`BRIDGE_DATA_W-1:0]                     apb_rdata,
	output logic                                          apb_err
);

	localparam int CNT_W = $clog2(`BRIDGE_TIMEOUT_CYCLES + 1);

	apb_phase_e                    phase;
	logic [CNT_W-1:0]              timer;
	logic [`BRIDGE_NUM_SLAVES-1:0] one_hot;
	logic                          sel_ready;
	logic                          sel_err;
	logic [`BRIDGE_DATA_W-1:0]     sel_rdata;
	logic                          timed_out;

	assign one_hot = `BRIDGE_NUM_SLAVES'(1) << xfer_slave;

	// xfer_slave stays put for the whole transfer.
	assign sel_ready = m_apb_pready[xfer_slave];
	assign sel_err   = m_apb_pslverr[xfer_slave];
	assign sel_rdata = m_apb_prdata[xfer_slave * `BRIDGE_DATA_W +: `BRIDGE_DATA_W];

	assign timed_out = (timer == CNT_W'(1));

	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			phase         <= ph_idle;
			timer         <= '0;
			m_apb_psel    <= '0;
			m_apb_penable <= 1'b0;
			m_apb_pwrite  <= 1'b0;
			apb_done      <= 1'b0;
		end else begin
			apb_done <= 1'b0;
			case (phase)
				ph_idle: begin
					if (xfer_start) begin
						phase        <= ph_setup;
						m_apb_psel   <= one_hot;
						m_apb_pwrite <= (xfer_kind == xfer_write);
					end
				end
				ph_setup: begin
					phase         <= ph_access;
					m_apb_penable <= 1'b1;
					timer         <= CNT_W'(`BRIDGE_TIMEOUT_CYCLES);
				end
				ph_access: begin
					if (sel_ready || timed_out) begin
						phase         <= ph_idle;
						m_apb_psel    <= '0;
						m_apb_penable <= 1'b0;
						m_apb_pwrite  <= 1'b0;
						apb_done      <= 1'b1;
					end else begin
						timer <= timer - CNT_W'(1);
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// address and write data hold from setup to the end of access.
	always_ff @(posedge s_axi_clk) begin
		if ((phase == ph_idle) && xfer_start) begin
			m_apb_paddr  <= xfer_addr;
			m_apb_pwdata <= xfer_wdata;
		end
		if (phase == ph_access) begin
			if (sel_ready) begin
				apb_rdata <= sel_rdata;
				apb_err   <= sel_err;
			end else if (timed_out) begin
				apb_rdata <= '0;
				apb_err   <= 1'b1;
			end
		end
	end

endmodule

// File: source/axi_request_decode.sv
////////////////////////////////////////////////////////////////////////////
// AXI-Lite request decode.
// Accepts read and write requests one at a time, captures address and
// data, picks the APB slave from the address region and launches either
// an APB transfer or a decode error.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bridge_macros.svh"

module axi_request_decode
	import bridge_pkg::*;
(
	input  logic                           s_axi_clk,
	input  logic                           s_axi_aresetn,

	input  logic [`BRIDGE_ADDR_W-1:0]      s_axi_awaddr,
	input  logic                           s_axi_awvalid,
	output logic                           s_axi_awready,
	input  logic [`BRIDGE_DATA_W-1:0]      s_axi_wdata,
	input  logic                           s_axi_wvalid,
	output logic                           s_axi_wready,
	input  logic [`BRIDGE_ADDR_W-1:0]      s_axi_araddr,
	input  logic                           s_axi_arvalid,
	output logic                           s_axi_arready,

	input  logic                           resp_done,

	output logic                           xfer_start,
	output logic                           decerr_start,
	output xfer_kind_e                     xfer_kind,
	output logic [`BRIDGE_ADDR_W-1:0]      xfer_addr,
	output logic [`BRIDGE_DATA_W-1:0]      xfer_wdata,
	output logic [`BRIDGE_SLAVE_SEL_W-1:0] xfer_slave
);

	bridge_state_e state;
	logic          launch;
	logic          in_range;
	logic          ar_take;
	logic          aw_take;
	logic          w_take;

	// read wins when both kinds are offered in idle.
	assign ar_take = (state == st_idle) && s_axi_arvalid;
	assign aw_take = s_axi_awvalid &&
		(((state == st_idle) && !s_axi_arvalid) || (state == st_wait_addr));
	assign w_take  = s_axi_wvalid &&
		(((state == st_idle) && !s_axi_arvalid) || (state == st_wait_data));

	assign s_axi_arready = ar_take;
	assign s_axi_awready = aw_take;
	assign s_axi_wready  = w_take;

	// region index above the last slave is a decode error.
	assign in_range   = (xfer_addr >> `BRIDGE_REGION_LOG2) < `BRIDGE_NUM_SLAVES;
	assign xfer_slave = xfer_addr[`BRIDGE_REGION_LOG2 +: `BRIDGE_SLAVE_SEL_W];

	assign xfer_start   = launch && in_range;
	assign decerr_start = launch && !in_range;

	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			state     <= st_idle;
			launch    <= 1'b0;
			xfer_kind <= xfer_read;
		end else begin
			launch <= 1'b0;
			case (state)
				st_idle: begin
					if (ar_take) begin
						xfer_kind <= xfer_read;
						state     <= st_busy;
						launch    <= 1'b1;
					end else if (aw_take && w_take) begin
						xfer_kind <= xfer_write;
						state     <= st_busy;
						launch    <= 1'b1;
					end else if (aw_take) begin
						xfer_kind <= xfer_write;
						state     <= st_wait_data;
					end else if (w_take) begin
						xfer_kind <= xfer_write;
						state     <= st_wait_addr;
					end
				end
				st_wait_data: begin
					if (w_take) begin
						state  <= st_busy;
						launch <= 1'b1;
					end
				end
				st_wait_addr: begin
					if (aw_take) begin
						state  <= st_busy;
						launch <= 1'b1;
					end
				end
				st_busy: begin
					// held here until the response handshake.
					if (resp_done) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request payload, only written while a half is accepted.
	always_ff @(posedge s_axi_clk) begin
		if (ar_take) begin
			xfer_addr <= s_axi_araddr;
		end else if (aw_take) begin
			xfer_addr <= s_axi_awaddr;
		end
		if (w_take) begin
			xfer_wdata <= s_axi_wdata;
		end
	end

endmodule

// File: source/bridge_pkg.sv
////////////////////////////////////////////////////////////////////////////
// AXI-Lite to APB3 bridge, shared types.
// FSM states, APB phases, transfer opcodes and AXI response codes.
////////////////////////////////////////////////////////////////////////////

package bridge_pkg;

	// request decode FSM.
	typedef enum logic [1:0] {
		st_idle      = 2'd0,
		st_wait_data = 2'd1,
		st_wait_addr = 2'd2,
		st_busy      = 2'd3
	} bridge_state_e;

	// APB transfer phases.
	typedef enum logic [1:0] {
		ph_idle   = 2'd0,
		ph_setup  = 2'd1,
		ph_access = 2'd2
	} apb_phase_e;

	typedef enum logic {
		xfer_read  = 1'b0,
		xfer_write = 1'b1
	} xfer_kind_e;

	// AXI RRESP/BRESP encodings.
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

endpackage

// File: source/bridge_macros.svh
////////////////////////////////////////////////////////////////////////////
// AXI-Lite to APB3 bridge, shared sizing constants.
// Bus widths, number of APB slaves, slave region size and the
// access timeout used by the transfer engine.
////////////////////////////////////////////////////////////////////////////

`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// address and data bus widths.
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// four APB slaves, indexed by two address bits.
`define BRIDGE_NUM_SLAVES 4
`define BRIDGE_SLAVE_SEL_W 2

// each slave owns a 4 KiB region starting at address 0.
`define BRIDGE_REGION_LOG2 12

// access cycles without PREADY before the transfer is ended.
`define BRIDGE_TIMEOUT_CYCLES 16

`endif
